// File: hw/memsys_pkg.sv
`default_nettype none

package memsys_pkg;

    // ####################
    // bus structs
    // ####################

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic        wen;
        logic [31:0] wdata;
    } cache_req_t;

    typedef struct packed {
        logic        valid;
        logic        error;
        logic [31:0] rdata;
    } cache_resp_t;

    // ####################
    // address map
    // ####################

    localparam logic [31:0] MMIO_BASE = 32'hf000_0000; // only the upper 20 bits are compared

    typedef enum logic [11:0] {
        REG_UART_TX   = 12'h000,
        REG_UART_RX   = 12'h004,
        REG_UART_STAT = 12'h008, // bit 0 tx busy, bit 1 rx pending
        REG_MTIME     = 12'h010,
        REG_MTIMECMP  = 12'h018
    } mmio_reg_e;

    // ####################
    // state machines
    // ####################

    typedef enum logic [1:0] {ARB_IDLE, ARB_PTE, ARB_DATA} arb_state_e;

    typedef enum logic [1:0] {UART_IDLE, UART_START, UART_DATA, UART_STOP} uart_state_e;

endpackage

`default_nettype wire

// File: hw/delay_memory.sv
`timescale 1ns/1ps
`default_nettype none

module delay_memory import memsys_pkg::*; #(
    parameter int MEM_WIDTH   = 12,
    parameter int DELAY_CYCLE = 4
) (
    input  wire         clk27MHz,
    input  wire         rst,
    input  wire cache_req_t  mem_req,
    output logic        mem_ready,
    output cache_resp_t mem_resp
);

    localparam int CNT_W = $clog2(DELAY_CYCLE + 1);

    logic [31:0]            mem [2**(MEM_WIDTH-2)];
    logic                   busy;
    logic [CNT_W-1:0]       cnt;
    logic                   err_q;
    logic [31:0]            rdata_q;
    logic                   accept;
    logic                   out_of_range;
    logic [MEM_WIDTH-3:0]   word_idx;

    assign mem_ready    = !busy;
    assign accept       = mem_req.valid && mem_ready;
    assign out_of_range = |mem_req.addr[31:MEM_WIDTH];
    assign word_idx     = mem_req.addr[MEM_WIDTH-1:2];

    always_ff @(posedge clk27MHz) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            cnt  <= CNT_W'(DELAY_CYCLE - 1); // response lands when this reaches zero
        end else if (busy) begin
            if (cnt == '0) begin
                busy <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // the access itself happens at acceptance, only the answer is delayed
    always_ff @(posedge clk27MHz) begin
        if (accept) begin
            err_q <= out_of_range;
            if (mem_req.wen || out_of_range) begin
                rdata_q <= '0;
            end else begin
                rdata_q <= mem[word_idx];
            end
            if (mem_req.wen && !out_of_range) begin
                mem[word_idx] <= mem_req.wdata;
            end
        end
    end

    assign mem_resp.valid = busy && (cnt == '0);
    assign mem_resp.error = err_q;
    assign mem_resp.rdata = rdata_q;

endmodule

`default_nettype wire

// File: hw/cache_cmd_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cache_cmd_arbiter import memsys_pkg::*; (
    input  wire         clk27MHz,
    input  wire         rst,

    input  wire cache_req_t  pte_req,
    output logic        pte_ready,
    output cache_resp_t pte_resp,

    input  wire cache_req_t  data_req,
    output logic        data_ready,
    output cache_resp_t data_resp,

    output cache_req_t  mem_req,
    input  wire         mem_ready,
    input  wire cache_resp_t mem_resp
);

    arb_state_e state;
    logic       idle;

    assign idle = (state == ARB_IDLE);

    // pte port wins a tie
    always_comb begin
        mem_req = '0;
        if (idle) begin
            mem_req = pte_req.valid ? pte_req : data_req;
        end
    end

    assign pte_ready  = idle && mem_ready;
    assign data_ready = idle && mem_ready && !pte_req.valid;

    always_ff @(posedge clk27MHz) begin
        if (rst) begin
            state <= ARB_IDLE;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (mem_req.valid && mem_ready) begin
                        state <= pte_req.valid ? ARB_PTE : ARB_DATA;
                    end
                end
                ARB_PTE, ARB_DATA: begin
                    if (mem_resp.valid) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // the response goes back to whoever holds the grant
    always_comb begin
        pte_resp  = mem_resp;
        data_resp = mem_resp;
        pte_resp.valid  = mem_resp.valid && (state == ARB_PTE);
        data_resp.valid = mem_resp.valid && (state == ARB_DATA);
    end

endmodule

`default_nettype wire

// File: hw/uart_phy.sv
`timescale 1ns/1ps
`default_nettype none

module uart_phy import memsys_pkg::*; #(
    parameter int CLKS_PER_BIT = 234
) (
    input  wire        clk27MHz,
    input  wire        rst,
    input  wire        tx_start,
    input  wire [7:0]  tx_byte,
    output logic       tx_busy,
    output logic       uart_tx,
    input  wire        uart_rx,
    output logic       rx_valid,
    output logic [7:0] rx_byte
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CW-1:0] LAST = CW'(CLKS_PER_BIT - 1);
    localparam logic [CW-1:0] HALF = CW'((CLKS_PER_BIT - 1) / 2);

    // ####################
    // transmitter
    // ####################

    uart_state_e   tx_state;
    logic [CW-1:0] tx_cnt;
    logic [2:0]    tx_bit;
    logic [7:0]    tx_shift;
    logic          tx_last;

    assign tx_busy = (tx_state != UART_IDLE);
    assign tx_last = (tx_cnt == LAST);

    always_ff @(posedge clk27MHz) begin
        if (rst) begin
            tx_state <= UART_IDLE;
            tx_cnt   <= '0;
            tx_bit   <= '0;
            uart_tx  <= 1'b1;
        end else begin
            tx_cnt <= tx_last ? '0 : tx_cnt + 1'b1;
            case (tx_state)
                UART_IDLE: begin
                    tx_cnt <= '0;
                    if (tx_start) begin
                        tx_state <= UART_START;
                        tx_shift <= tx_byte;
                        uart_tx  <= 1'b0;
                    end
                end
                UART_START: begin
                    if (tx_last) begin
                        tx_state <= UART_DATA;
                        tx_bit   <= '0;
                        uart_tx  <= tx_shift[0]; // lsb first
                        tx_shift <= tx_shift >> 1;
                    end
                end
                UART_DATA: begin
                    if (tx_last) begin
                        tx_bit <= tx_bit + 1'b1;
                        if (tx_bit == 3'd7) begin
                            tx_state <= UART_STOP;
                            uart_tx  <= 1'b1;
                        end else begin
                            uart_tx  <= tx_shift[0];
                            tx_shift <= tx_shift >> 1;
                        end
                    end
                end
                UART_STOP: begin
                    if (tx_last) begin
                        tx_state <= UART_IDLE;
                    end
                end
                default: tx_state <= UART_IDLE;
            endcase
        end
    end

    // ####################
    // receiver
    // ####################

    uart_state_e   rx_state;
    logic [CW-1:0] rx_cnt;
    logic [2:0]    rx_bit;
    logic [7:0]    rx_shift;
    logic          rx_s1;
    logic          rx_s2;
    logic          rx_last;

    assign rx_last = (rx_cnt == LAST);

    always_ff @(posedge clk27MHz) begin
        if (rst) begin
            rx_s1    <= 1'b1;
            rx_s2    <= 1'b1;
            rx_state <= UART_IDLE;
            rx_cnt   <= '0;
            rx_bit   <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_s1    <= uart_rx;
            rx_s2    <= rx_s1;
            rx_valid <= 1'b0;
            rx_cnt   <= rx_cnt + 1'b1;
            case (rx_state)
                UART_IDLE: begin
                    rx_cnt <= '0;
                    if (!rx_s2) begin
                        rx_state <= UART_START;
                    end
                end
                UART_START: begin
                    if (rx_cnt == HALF) begin // middle of the start bit
                        rx_cnt   <= '0;
                        rx_bit   <= '0;
                        rx_state <= rx_s2 ? UART_IDLE : UART_DATA;
                    end
                end
                UART_DATA: begin
                    if (rx_last) begin
                        rx_cnt   <= '0;
                        rx_shift <= {rx_s2, rx_shift[7:1]};
                        rx_bit   <= rx_bit + 1'b1;
                        if (rx_bit == 3'd7) begin
                            rx_state <= UART_STOP;
                        end
                    end
                end
                UART_STOP: begin
                    if (rx_last) begin
                        rx_state <= UART_IDLE;
                        rx_valid <= rx_s2; // framing error drops the byte
                        rx_byte  <= rx_shift;
                    end
                end
                default: rx_state <= UART_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/mmio_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_regs import memsys_pkg::*; #(
    parameter int CLKS_PER_BIT = 234
) (
    input  wire         clk27MHz,
    input  wire         rst,

    input  wire mmio_reg_e   reg_sel,
    input  wire         reg_wen,
    input  wire [31:0]  reg_wdata,
    input  wire         reg_strobe,
    output logic [31:0] reg_rdata,
    output logic        reg_err,

    input  wire         uart_rx,
    output logic        uart_tx,
    output logic        mti_pending,
    output logic        uart_rx_pending
);

    logic [31:0] mtime;
    logic [31:0] mtimecmp;
    logic [7:0]  rx_buf;
    logic        rx_pend;

    logic        tx_start;
    logic        tx_busy;
    logic        rx_valid;
    logic [7:0]  rx_byte;
    logic        wr;
    logic        rd;

    assign wr = reg_strobe && reg_wen;
    assign rd = reg_strobe && !reg_wen;

    assign tx_start = wr && (reg_sel == REG_UART_TX) && !tx_busy; // busy writes are dropped

    // ####################
    // machine timer
    // ####################

    always_ff @(posedge clk27MHz) begin
        if (rst) begin
            mtime    <= '0;
            mtimecmp <= '1;
        end else begin
            if (wr && reg_sel == REG_MTIME) begin
                mtime <= reg_wdata;
            end else begin
                mtime <= mtime + 1'b1;
            end
            if (wr && reg_sel == REG_MTIMECMP) begin
                mtimecmp <= reg_wdata;
            end
        end
    end

    assign mti_pending = (mtime >= mtimecmp);

    // a new byte wins over a clearing read of the receive buffer
    always_ff @(posedge clk27MHz) begin
        if (rst) begin
            rx_pend <= 1'b0;
        end else if (rx_valid) begin
            rx_pend <= 1'b1;
        end else if (rd && reg_sel == REG_UART_RX) begin
            rx_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk27MHz) begin
        if (rx_valid) begin
            rx_buf <= rx_byte;
        end
    end

    assign uart_rx_pending = rx_pend;

    always_comb begin
        reg_rdata = '0;
        reg_err   = 1'b0;
        case (reg_sel)
            REG_UART_TX:   reg_rdata = '0;
            REG_UART_RX:   reg_rdata = {24'h0, rx_buf};
            REG_UART_STAT: reg_rdata = {30'h0, rx_pend, tx_busy};
            REG_MTIME:     reg_rdata = mtime;
            REG_MTIMECMP:  reg_rdata = mtimecmp;
            default:       reg_err   = 1'b1; // unmapped offset in the page
        endcase
    end

    uart_phy #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) uart_phy_i (
        .clk27MHz(clk27MHz),
        .rst(rst),
        .tx_start(tx_start),
        .tx_byte(reg_wdata[7:0]),
        .tx_busy(tx_busy),
        .uart_tx(uart_tx),
        .uart_rx(uart_rx),
        .rx_valid(rx_valid),
        .rx_byte(rx_byte)
    );

endmodule

`default_nettype wire

// File: hw/mmio_cntr.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_cntr import memsys_pkg::*; #(
    parameter int CLKS_PER_BIT = 234
) (
    input  wire         clk27MHz,
    input  wire         rst,

    input  wire cache_req_t  data_req,
    output logic        data_ready,
    output cache_resp_t data_resp,

    output cache_req_t  fwd_req,
    input  wire         fwd_ready,
    input  wire cache_resp_t fwd_resp,

    input  wire         uart_rx,
    output logic        uart_tx,
    output logic        mti_pending,
    output logic        uart_rx_pending
);

    mmio_reg_e   reg_sel;
    logic        reg_wen;
    logic [31:0] reg_wdata;
    logic        reg_strobe;
    logic [31:0] reg_rdata;
    logic        reg_err;

    logic        is_mmio;
    logic        outstanding;
    logic        mmio_pend;
    logic        fwd_busy;
    logic        mmio_err_q;
    logic [31:0] mmio_rdata_q;

    assign is_mmio     = (data_req.addr[31:12] == MMIO_BASE[31:12]);
    assign outstanding = mmio_pend || fwd_busy; // one response in flight at most

    assign data_ready = !outstanding && (is_mmio || fwd_ready);

    always_comb begin
        fwd_req       = data_req;
        fwd_req.valid = data_req.valid && !is_mmio && !outstanding;
    end

    // ####################
    // register access
    // ####################

    assign reg_strobe = data_req.valid && is_mmio && !outstanding;
    assign reg_sel    = mmio_reg_e'(data_req.addr[11:0]);
    assign reg_wen    = data_req.wen;
    assign reg_wdata  = data_req.wdata;

    always_ff @(posedge clk27MHz) begin
        if (rst) begin
            mmio_pend <= 1'b0;
            fwd_busy  <= 1'b0;
        end else begin
            mmio_pend <= reg_strobe;
            if (fwd_req.valid && fwd_ready) begin
                fwd_busy <= 1'b1;
            end else if (fwd_resp.valid) begin
                fwd_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk27MHz) begin
        if (reg_strobe) begin
            mmio_err_q   <= reg_err;
            mmio_rdata_q <= reg_wen ? 32'h0 : reg_rdata; // writes answer with zero
        end
    end

    always_comb begin
        if (mmio_pend) begin
            data_resp.valid = 1'b1;
            data_resp.error = mmio_err_q;
            data_resp.rdata = mmio_rdata_q;
        end else begin
            data_resp = fwd_resp;
        end
    end

    mmio_regs #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) mmio_regs_i (
        .clk27MHz(clk27MHz),
        .rst(rst),
        .reg_sel(reg_sel),
        .reg_wen(reg_wen),
        .reg_wdata(reg_wdata),
        .reg_strobe(reg_strobe),
        .reg_rdata(reg_rdata),
        .reg_err(reg_err),
        .uart_rx(uart_rx),
        .uart_tx(uart_tx),
        .mti_pending(mti_pending),
        .uart_rx_pending(uart_rx_pending)
    );

endmodule

`default_nettype wire

// File: hw/mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys import memsys_pkg::*; #(
    parameter int MEM_WIDTH    = 12,
    parameter int DELAY_CYCLE  = 4,
    parameter int CLKS_PER_BIT = 234 // 27 MHz at 115200 baud
) (
    input  wire         clk27MHz,
    input  wire         rst,
    input  wire         uart_rx,
    output logic        uart_tx,

    input  wire cache_req_t  pte_req,
    output logic        pte_ready,
    output cache_resp_t pte_resp,

    input  wire cache_req_t  data_req,
    output logic        data_ready,
    output cache_resp_t data_resp,

    output logic        mti_pending,
    output logic        uart_rx_pending
);

    cache_req_t  fwd_req;
    logic        fwd_ready;
    cache_resp_t fwd_resp;
    cache_req_t  mem_req;
    logic        mem_ready;
    cache_resp_t mem_resp;

    mmio_cntr #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) mmio_cntr_i (
        .clk27MHz(clk27MHz),
        .rst(rst),
        .data_req(data_req),
        .data_ready(data_ready),
        .data_resp(data_resp),
        .fwd_req(fwd_req),
        .fwd_ready(fwd_ready),
        .fwd_resp(fwd_resp),
        .uart_rx(uart_rx),
        .uart_tx(uart_tx),
        .mti_pending(mti_pending),
        .uart_rx_pending(uart_rx_pending)
    );

    cache_cmd_arbiter cache_cmd_arbiter_i (
        .clk27MHz(clk27MHz),
        .rst(rst),
        .pte_req(pte_req),
        .pte_ready(pte_ready),
        .pte_resp(pte_resp),
        .data_req(fwd_req),
        .data_ready(fwd_ready),
        .data_resp(fwd_resp),
        .mem_req(mem_req),
        .mem_ready(mem_ready),
        .mem_resp(mem_resp)
    );

    delay_memory #(
        .MEM_WIDTH(MEM_WIDTH),
        .DELAY_CYCLE(DELAY_CYCLE)
    ) delay_memory_i (
        .clk27MHz(clk27MHz),
        .rst(rst),
        .mem_req(mem_req),
        .mem_ready(mem_ready),
        .mem_resp(mem_resp)
    );

endmodule

`default_nettype wire

// File: testbench/mem_subsys_chk.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_chk import memsys_pkg::*; (
    input wire              clk27MHz,
    input wire              rst,
    input wire cache_req_t  pte_req,
    input wire              pte_ready,
    input wire cache_resp_t pte_resp,
    input wire cache_req_t  data_req,
    input wire              data_ready,
    input wire cache_resp_t data_resp,
    input wire              mti_pending,
    input wire              uart_tx
);

    int fail_count = 0;

    // ####################
    // handshakes
    // ####################

    a_pte_req_stable: assert property (@(posedge clk27MHz) disable iff (rst)
        pte_req.valid && !pte_ready |=> $stable(pte_req))
    else begin
        fail_count++;
        $error("pte_req changed while pte_ready was low");
    end

    a_data_req_stable: assert property (@(posedge clk27MHz) disable iff (rst)
        data_req.valid && !data_ready |=> $stable(data_req))
    else begin
        fail_count++;
        $error("data_req changed while data_ready was low");
    end

    a_pte_resp_pulse: assert property (@(posedge clk27MHz) disable iff (rst)
        pte_resp.valid |=> !pte_resp.valid)
    else begin
        fail_count++;
        $error("pte_resp.valid was high for two cycles in a row");
    end

    a_data_resp_pulse: assert property (@(posedge clk27MHz) disable iff (rst)
        data_resp.valid |=> !data_resp.valid)
    else begin
        fail_count++;
        $error("data_resp.valid was high for two cycles in a row");
    end

    // ####################
    // reset state
    // ####################

    a_reset_state: assert property (@(posedge clk27MHz)
        rst |=> !mti_pending && uart_tx && pte_ready && data_ready
                && !pte_resp.valid && !data_resp.valid)
    else begin
        fail_count++;
        $error("outputs not in their idle state after reset");
    end

endmodule

bind mem_subsys mem_subsys_chk chk_i (
    .clk27MHz(clk27MHz),
    .rst(rst),
    .pte_req(pte_req),
    .pte_ready(pte_ready),
    .pte_resp(pte_resp),
    .data_req(data_req),
    .data_ready(data_ready),
    .data_resp(data_resp),
    .mti_pending(mti_pending),
    .uart_tx(uart_tx)
);

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 16
) (
    output logic clk27MHz,
    output logic rst
);

    initial begin
        clk27MHz = 1'b0;
        forever begin
            #(PERIOD / 2) clk27MHz = ~clk27MHz;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk27MHz);
        @(negedge clk27MHz);
        rst = 1'b0; // released away from the active edge
    end

endmodule

`default_nettype wire

// File: testbench/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys import memsys_pkg::*; ();

    localparam int          CLKS_PER_BIT    = 8;
    localparam int          MEM_WIDTH       = 12;
    localparam int          DELAY_CYCLE     = 4;
    localparam int          NUM_WORDS       = 16;
    localparam int          WATCHDOG_CYCLES = 20000; // about 20x the ~1000 cycles of all tests
    localparam logic [31:0] MEM_LIMIT       = 32'h1 << MEM_WIDTH;

    logic        clk27MHz;
    logic        rst;
    logic        uart_rx;
    logic        uart_tx;
    cache_req_t  pte_req;
    logic        pte_ready;
    cache_resp_t pte_resp;
    cache_req_t  data_req;
    logic        data_ready;
    cache_resp_t data_resp;
    logic        mti_pending;
    logic        uart_rx_pending;

    int          seed = 62358;
    int          value_errors = 0;
    int          cycle = 0;
    logic [31:0] model [2**(MEM_WIDTH-2)];
    logic [31:0] addrs [NUM_WORDS];

    tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(16)) clock_gen_i (.clk27MHz(clk27MHz), .rst(rst));

    assign uart_rx = rst ? 1'b1 : uart_tx; // looped back and held idle until reset is released

    mem_subsys #(
        .MEM_WIDTH(MEM_WIDTH),
        .DELAY_CYCLE(DELAY_CYCLE),
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) mem_subsys_i (
        .clk27MHz(clk27MHz),
        .rst(rst),
        .uart_rx(uart_rx),
        .uart_tx(uart_tx),
        .pte_req(pte_req),
        .pte_ready(pte_ready),
        .pte_resp(pte_resp),
        .data_req(data_req),
        .data_ready(data_ready),
        .data_resp(data_resp),
        .mti_pending(mti_pending),
        .uart_rx_pending(uart_rx_pending)
    );

    always @(posedge clk27MHz) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] mmio_addr(input mmio_reg_e sel);
        return MMIO_BASE | {20'h0, sel};
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("Error at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond) else begin
            value_errors++;
            $display("Check failed at %0t: %s", $time, what);
        end
    endtask

    task automatic check_response(input string port, input cache_resp_t resp,
                                  input logic exp_error, input logic [31:0] exp_rdata);
        expect_equal({port, ".error"}, 32'(resp.error), 32'(exp_error));
        expect_equal({port, ".rdata"}, resp.rdata, exp_rdata);
    endtask

    // latency counts cycles from the accepting edge to the response cycle
    task automatic data_access(input logic [31:0] addr, input logic wen, input logic [31:0] wdata,
                               output cache_resp_t resp, output int latency, output int done);
        logic accepted;
        accepted = 1'b0;
        @(negedge clk27MHz);
        data_req.valid = 1'b1;
        data_req.addr  = addr;
        data_req.wen   = wen;
        data_req.wdata = wdata;
        while (!accepted) begin
            @(posedge clk27MHz);
            accepted = data_ready;
        end
        @(negedge clk27MHz);
        data_req = '0;
        latency  = 1;
        while (!data_resp.valid) begin
            @(negedge clk27MHz);
            latency++;
        end
        resp = data_resp;
        done = cycle;
    endtask

    task automatic pte_access(input logic [31:0] addr, output cache_resp_t resp, output int done);
        logic accepted;
        accepted = 1'b0;
        @(negedge clk27MHz);
        pte_req.valid = 1'b1;
        pte_req.addr  = addr;
        pte_req.wen   = 1'b0;
        pte_req.wdata = '0;
        while (!accepted) begin
            @(posedge clk27MHz);
            accepted = pte_ready;
        end
        @(negedge clk27MHz);
        pte_req = '0;
        while (!pte_resp.valid) begin
            @(negedge clk27MHz);
        end
        resp = pte_resp;
        done = cycle;
    endtask

    task automatic finish_run(input logic timed_out);
        int assert_fails;
        assert_fails = mem_subsys_i.chk_i.fail_count;
        $display("value errors: %0d, assertion failures: %0d, timeout: %0d",
                 value_errors, assert_fails, timed_out);
        if (value_errors == 0 && assert_fails == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk27MHz);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        finish_run(1'b1);
    end

    initial begin
        cache_resp_t resp;
        cache_resp_t pte_rsp;
        int          lat;
        int          done;
        int          pte_done;
        int          data_done;
        logic [31:0] word;
        logic [31:0] pte_word;
        logic [7:0]  tx_byte;
        logic [31:0] t0;
        int          waited;

        pte_req  = '0;
        data_req = '0;
        @(negedge clk27MHz);
        while (rst) begin
            @(negedge clk27MHz);
        end

        // ####################
        // memory through both ports
        // ####################

        for (int i = 0; i < NUM_WORDS; i++) begin
            addrs[i] = $random(seed) & (MEM_LIMIT - 32'd4);
            word     = $random(seed);
            model[addrs[i][MEM_WIDTH-1:2]] = word;
            data_access(addrs[i], 1'b1, word, resp, lat, done);
            check_response("data_resp", resp, 1'b0, 32'h0);
            expect_equal("write latency", lat, DELAY_CYCLE);
        end
        for (int i = 0; i < NUM_WORDS; i++) begin
            data_access(addrs[i], 1'b0, 32'h0, resp, lat, done);
            check_response("data_resp", resp, 1'b0, model[addrs[i][MEM_WIDTH-1:2]]);
            expect_equal("read latency", lat, DELAY_CYCLE);
        end

        data_access(MEM_LIMIT, 1'b0, 32'h0, resp, lat, done); // first byte past the array
        check_response("data_resp", resp, 1'b1, 32'h0);

        pte_word = $random(seed);
        word     = $random(seed);
        data_access(32'h0000_07f0, 1'b1, pte_word, resp, lat, done);
        data_access(32'h0000_03a4, 1'b1, word, resp, lat, done);
        fork
            pte_access(32'h0000_07f0, pte_rsp, pte_done);
            data_access(32'h0000_03a4, 1'b0, 32'h0, resp, lat, data_done);
        join
        check_response("pte_resp", pte_rsp, 1'b0, pte_word);
        check_response("data_resp", resp, 1'b0, word);
        expect_true(pte_done < data_done, "the data request was served before the PTE request");

        // a PTE request raised one cycle after a data read waits until that read is answered
        fork
            data_access(32'h0000_03a4, 1'b0, 32'h0, resp, lat, data_done);
            begin
                @(negedge clk27MHz);
                pte_access(32'h0000_07f0, pte_rsp, pte_done);
            end
        join
        check_response("pte_resp", pte_rsp, 1'b0, pte_word);
        check_response("data_resp", resp, 1'b0, word);
        expect_true(data_done < pte_done, "the PTE request overtook the data read in flight");

        // ####################
        // UART loopback and timer
        // ####################

        tx_byte = 8'($random(seed));
        data_access(mmio_addr(REG_UART_TX), 1'b1, {24'h0, tx_byte}, resp, lat, done);
        check_response("data_resp", resp, 1'b0, 32'h0);
        expect_equal("mmio latency", lat, 1);
        data_access(mmio_addr(REG_UART_STAT), 1'b0, 32'h0, resp, lat, done);
        check_response("data_resp", resp, 1'b0, 32'h1); // only tx busy
        waited = 0;
        while (!uart_rx_pending && waited < 20 * CLKS_PER_BIT) begin
            @(negedge clk27MHz);
            waited++;
        end
        expect_true(uart_rx_pending, "uart_rx_pending did not rise after the looped back byte");
        data_access(mmio_addr(REG_UART_RX), 1'b0, 32'h0, resp, lat, done);
        check_response("data_resp", resp, 1'b0, {24'h0, tx_byte});
        expect_true(!uart_rx_pending, "uart_rx_pending stayed high after the receive read");

        data_access(mmio_addr(REG_MTIME), 1'b0, 32'h0, resp, lat, done);
        t0 = resp.rdata;
        data_access(mmio_addr(REG_MTIMECMP), 1'b1, t0 + 32'd200, resp, lat, done);
        expect_true(!mti_pending, "mti_pending was high right after mtimecmp was set ahead");
        data_access(mmio_addr(REG_MTIMECMP), 1'b0, 32'h0, resp, lat, done);
        check_response("data_resp", resp, 1'b0, t0 + 32'd200);
        repeat (300) @(negedge clk27MHz);
        expect_true(mti_pending, "mti_pending did not rise once mtime reached mtimecmp");
        data_access(mmio_addr(REG_MTIMECMP), 1'b1, 32'hffff_ffff, resp, lat, done);
        expect_true(!mti_pending, "mti_pending stayed high after mtimecmp was set to all ones");

        data_access(MMIO_BASE + 32'h20, 1'b0, 32'h0, resp, lat, done); // unmapped offset
        check_response("data_resp", resp, 1'b1, 32'h0);
        expect_equal("mmio latency", lat, 1);

        finish_run(1'b0);
    end

endmodule

`default_nettype wire

// File: memsys.f
hw/memsys_pkg.sv
hw/delay_memory.sv
hw/cache_cmd_arbiter.sv
hw/uart_phy.sv
hw/mmio_regs.sv
hw/mmio_cntr.sv
hw/mem_subsys.sv
testbench/mem_subsys_chk.sv
testbench/tb_clock_gen.sv
testbench/tb_mem_subsys.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the memsys testbench with Verilator, then judge the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsys \
    -f memsys.f -o sim_memsys \
    && ./obj_dir/sim_memsys +verilator+error+limit+1000 | tee sim.log \
    || { echo "build or simulation failed"; exit 1; }

grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
